//--- Makefile
# Verilator simulation of the RV32C expander
TOP = tb_rvc_expander

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	-./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- list.f
source/rvc_expand_pkg.sv
source/rvc_mem_expander.sv
source/rvc_alu_expander.sv
source/rvc_expand_ctrl.sv
source/rvc_expander_top.sv
testbench/rvc_expander_checker.sv
testbench/tb_rvc_expander.sv

//--- source/rvc_alu_expander.sv
`timescale 1ns/10ps
//--------------------------------------------------------------------
// Combinational expander for the RV32C integer arithmetic group
// Quadrant 2 function 100 is claimed as a whole, so jumps and
// C.EBREAK in that slot come out claimed but not legal
// Shift amounts with bit 12 set are RV64 only and are rejected
//--------------------------------------------------------------------
module rvc_alu_expander import rvc_expand_pkg::*; (
    input  cinstr_t compressed_i,
    output logic    claim_o,
    output logic    legal_o,
    output instr_t  expanded_o
);

    logic [1:0]  quad;
    logic [2:0]  funct3;
    logic        bit12;
    reg_idx_t    rd_full;
    reg_idx_t    rs2_full;
    reg_idx_t    reg_hi_prime;
    reg_idx_t    reg_lo_prime;
    logic [11:0] ci_imm;
    logic        ci_imm_nonzero;
    logic [4:0]  shamt;
    logic [2:0]  ca_funct3;
    logic [6:0]  ca_funct7;

    function automatic instr_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                      input logic [2:0] f3, input reg_idx_t rd,
                                      input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // R-type layout, the immediate shifts also use it with shamt in rs2
    function automatic instr_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3,
                                      input reg_idx_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    assign quad     = compressed_i[1:0];
    assign funct3   = compressed_i[15:13];
    assign bit12    = compressed_i[12];
    assign rd_full  = compressed_i[11:7];
    assign rs2_full = compressed_i[6:2];
    assign shamt    = compressed_i[6:2];

    assign reg_hi_prime = CREG_BASE + {2'b00, compressed_i[9:7]};
    assign reg_lo_prime = CREG_BASE + {2'b00, compressed_i[4:2]};

    // Six-bit signed immediate of the CI and CB forms
    assign ci_imm         = {{6{bit12}}, bit12, compressed_i[6:2]};
    assign ci_imm_nonzero = ({bit12, compressed_i[6:2]} != 6'd0);

    //----------------------------------------------------------------
    // Register-register group, selected by bits 6:5
    //----------------------------------------------------------------

    always_comb begin
        ca_funct7 = 7'b0000000;
        case (compressed_i[6:5])
            2'b00: begin
                ca_funct3 = 3'b000;
                ca_funct7 = 7'b0100000;
            end
            2'b01:   ca_funct3 = 3'b100;
            2'b10:   ca_funct3 = 3'b110;
            default: ca_funct3 = 3'b111;
        endcase
    end

    always_comb begin
        claim_o    = 1'b0;
        legal_o    = 1'b0;
        expanded_o = '0;
        case ({quad, funct3})
            {QUAD_1, 3'b000}: begin
                // C.ADDI, the rd or immediate zero cases are NOP and hints
                claim_o    = 1'b1;
                legal_o    = (rd_full != REG_X0) && ci_imm_nonzero;
                expanded_o = i_type(ci_imm, rd_full, 3'b000, rd_full, OPC_OP_IMM);
            end
            {QUAD_1, 3'b010}: begin
                // C.LI is addi rd, x0, imm
                claim_o    = 1'b1;
                legal_o    = (rd_full != REG_X0);
                expanded_o = i_type(ci_imm, REG_X0, 3'b000, rd_full, OPC_OP_IMM);
            end
            {QUAD_1, 3'b100}: begin
                claim_o = 1'b1;
                case (compressed_i[11:10])
                    2'b00: begin
                        legal_o    = !bit12;
                        expanded_o = r_type(7'b0000000, shamt, reg_hi_prime, 3'b101,
                                            reg_hi_prime, OPC_OP_IMM);
                    end
                    2'b01: begin
                        legal_o    = !bit12;
                        expanded_o = r_type(7'b0100000, shamt, reg_hi_prime, 3'b101,
                                            reg_hi_prime, OPC_OP_IMM);
                    end
                    2'b10: begin
                        legal_o    = 1'b1;
                        expanded_o = i_type(ci_imm, reg_hi_prime, 3'b111, reg_hi_prime,
                                            OPC_OP_IMM);
                    end
                    default: begin
                        // Bit 12 set selects the RV64 word forms
                        legal_o    = !bit12;
                        expanded_o = r_type(ca_funct7, reg_lo_prime, reg_hi_prime,
                                            ca_funct3, reg_hi_prime, OPC_OP);
                    end
                endcase
            end
            {QUAD_2, 3'b000}: begin
                claim_o    = 1'b1;
                legal_o    = !bit12 && (rd_full != REG_X0);
                expanded_o = r_type(7'b0000000, shamt, rd_full, 3'b001, rd_full, OPC_OP_IMM);
            end
            {QUAD_2, 3'b100}: begin
                // C.MV adds to x0 and C.ADD adds to rd, zero rs2 means a jump or break
                claim_o    = 1'b1;
                legal_o    = (rd_full != REG_X0) && (rs2_full != REG_X0);
                expanded_o = r_type(7'b0000000, rs2_full, bit12 ? rd_full : REG_X0,
                                    3'b000, rd_full, OPC_OP);
            end
            default: claim_o = 1'b0;
        endcase
    end

endmodule : rvc_alu_expander

//--- source/rvc_expand_ctrl.sv
`timescale 1ns/10ps
//--------------------------------------------------------------------
// Picks the claiming expander result and serves it over a four-phase
// req/ack handshake. One request is held at a time, ack_o follows the
// request by one cycle and drops on the first edge that sees req_i low
//--------------------------------------------------------------------
module rvc_expand_ctrl import rvc_expand_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   req_i,
    input  logic   mem_claim_i,
    input  logic   mem_legal_i,
    input  instr_t mem_expanded_i,
    input  logic   alu_claim_i,
    input  logic   alu_legal_i,
    input  instr_t alu_expanded_i,
    output logic   ack_o,
    output instr_t decompressed_o,
    output logic   illegal_o
);

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } state_t;

    state_t state_q;
    instr_t sel_word;
    logic   sel_illegal;
    logic   accept;

    // The groups are disjoint, so at most one claim is high
    always_comb begin
        if (mem_claim_i) begin
            sel_word    = mem_expanded_i;
            sel_illegal = !mem_legal_i;
        end else if (alu_claim_i) begin
            sel_word    = alu_expanded_i;
            sel_illegal = !alu_legal_i;
        end else begin
            sel_word    = '0;
            sel_illegal = 1'b1;
        end
    end

    assign accept = (state_q == ST_IDLE) && req_i;
    assign ack_o  = (state_q == ST_ACK);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q        <= ST_IDLE;
            decompressed_o <= '0;
            illegal_o      <= 1'b0;
        end else begin
            if (accept) begin
                state_q        <= ST_ACK;
                decompressed_o <= sel_word;
                illegal_o      <= sel_illegal;
            end else if ((state_q == ST_ACK) && !req_i) begin
                state_q <= ST_IDLE;
            end
        end
    end

endmodule : rvc_expand_ctrl

//--- source/rvc_expand_pkg.sv
//--------------------------------------------------------------------
// Shared types and constants for the RV32C to RV32I expander
// Only the RV32I opcodes reached by the supported compressed subset
// are defined here
//--------------------------------------------------------------------
package rvc_expand_pkg;

    //----------------------------------------------------------------
    // Instruction word types
    //----------------------------------------------------------------

    // A 16-bit compressed word as fetched
    typedef logic [15:0] cinstr_t;

    // A full RV32I instruction word
    typedef logic [31:0] instr_t;

    // Index into the integer register file
    typedef logic [4:0] reg_idx_t;

    //----------------------------------------------------------------
    // RV32I major opcodes
    //----------------------------------------------------------------

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    //----------------------------------------------------------------
    // Fixed registers
    //----------------------------------------------------------------

    // Hard-wired zero
    localparam reg_idx_t REG_X0 = 5'd0;

    // Stack pointer, implicit base of the stack forms
    localparam reg_idx_t REG_SP = 5'd2;

    //----------------------------------------------------------------
    // Compressed encoding fields
    //----------------------------------------------------------------

    // Quadrant codes held in bits 1:0, quadrant 3 marks a 32-bit word
    localparam logic [1:0] QUAD_0 = 2'b00;
    localparam logic [1:0] QUAD_1 = 2'b01;
    localparam logic [1:0] QUAD_2 = 2'b10;

    // A 3-bit register field rs1', rs2' or rd' selects x8 to x15
    localparam logic [4:0] CREG_BASE = 5'd8;

endpackage : rvc_expand_pkg

//--- source/rvc_expander_top.sv
`timescale 1ns/10ps
//--------------------------------------------------------------------
// RV32C expander with a registered four-phase req/ack interface
// compressed_i must stay stable while req_i is high
// decompressed_o is undefined whenever illegal_o is high
//--------------------------------------------------------------------
module rvc_expander_top import rvc_expand_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    req_i,
    input  cinstr_t compressed_i,
    output logic    ack_o,
    output instr_t  decompressed_o,
    output logic    illegal_o
);

    logic   mem_claim;
    logic   mem_legal;
    instr_t mem_expanded;
    logic   alu_claim;
    logic   alu_legal;
    instr_t alu_expanded;

    // Both groups decode the same word in parallel
    rvc_mem_expander i_mem_expander (
        .compressed_i (compressed_i),
        .claim_o      (mem_claim),
        .legal_o      (mem_legal),
        .expanded_o   (mem_expanded)
    );

    rvc_alu_expander i_alu_expander (
        .compressed_i (compressed_i),
        .claim_o      (alu_claim),
        .legal_o      (alu_legal),
        .expanded_o   (alu_expanded)
    );

    rvc_expand_ctrl i_expand_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .mem_claim_i    (mem_claim),
        .mem_legal_i    (mem_legal),
        .mem_expanded_i (mem_expanded),
        .alu_claim_i    (alu_claim),
        .alu_legal_i    (alu_legal),
        .alu_expanded_i (alu_expanded),
        .ack_o          (ack_o),
        .decompressed_o (decompressed_o),
        .illegal_o      (illegal_o)
    );

endmodule : rvc_expander_top

//--- source/rvc_mem_expander.sv
`timescale 1ns/10ps
//--------------------------------------------------------------------
// Combinational expander for C.ADDI4SPN, C.LW, C.SW, C.LWSP, C.SWSP
// claim_o flags words of this group only, expanded_o is zero otherwise
// expanded_o is meaningful only while legal_o is high
//--------------------------------------------------------------------
module rvc_mem_expander import rvc_expand_pkg::*; (
    input  cinstr_t compressed_i,
    output logic    claim_o,
    output logic    legal_o,
    output instr_t  expanded_o
);

    logic [1:0] quad;
    logic [2:0] funct3;
    reg_idx_t   reg_lo_prime;
    reg_idx_t   reg_hi_prime;
    reg_idx_t   rd_full;
    reg_idx_t   rs2_full;
    logic [9:0] addi4spn_imm;
    logic [6:0] word_imm;
    logic [7:0] lwsp_imm;
    logic [7:0] swsp_imm;

    // I-type layout used by ADDI and LW
    function automatic instr_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                      input logic [2:0] f3, input reg_idx_t rd,
                                      input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // S-type layout splits the offset around the two source registers
    function automatic instr_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3,
                                      input logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    assign quad   = compressed_i[1:0];
    assign funct3 = compressed_i[15:13];

    // Short register fields map onto x8..x15
    assign reg_lo_prime = CREG_BASE + {2'b00, compressed_i[4:2]};
    assign reg_hi_prime = CREG_BASE + {2'b00, compressed_i[9:7]};
    assign rd_full      = compressed_i[11:7];
    assign rs2_full     = compressed_i[6:2];

    //----------------------------------------------------------------
    // Scattered unsigned offsets, all word aligned
    //----------------------------------------------------------------

    // nzuimm[9:6|5:4|3|2] from bits 10:7, 12:11, 5 and 6
    assign addi4spn_imm = {compressed_i[10:7], compressed_i[12:11],
                           compressed_i[5], compressed_i[6], 2'b00};
    // Shared by C.LW and C.SW, uimm[6|5:3|2]
    assign word_imm     = {compressed_i[5], compressed_i[12:10], compressed_i[6], 2'b00};
    assign lwsp_imm     = {compressed_i[3:2], compressed_i[12], compressed_i[6:4], 2'b00};
    assign swsp_imm     = {compressed_i[8:7], compressed_i[12:9], 2'b00};

    always_comb begin
        claim_o    = 1'b0;
        legal_o    = 1'b0;
        expanded_o = '0;
        case ({quad, funct3})
            {QUAD_0, 3'b000}: begin
                // addi rd', sp, nzuimm and a zero offset is reserved
                claim_o    = 1'b1;
                legal_o    = (addi4spn_imm != '0);
                expanded_o = i_type({2'b00, addi4spn_imm}, REG_SP, 3'b000,
                                    reg_lo_prime, OPC_OP_IMM);
            end
            {QUAD_0, 3'b010}: begin
                claim_o    = 1'b1;
                legal_o    = 1'b1;
                expanded_o = i_type({5'b0, word_imm}, reg_hi_prime, 3'b010,
                                    reg_lo_prime, OPC_LOAD);
            end
            {QUAD_0, 3'b110}: begin
                claim_o    = 1'b1;
                legal_o    = 1'b1;
                expanded_o = s_type({5'b0, word_imm}, reg_lo_prime, reg_hi_prime,
                                    3'b010, OPC_STORE);
            end
            {QUAD_2, 3'b010}: begin
                // Loading into x0 is reserved for C.LWSP
                claim_o    = 1'b1;
                legal_o    = (rd_full != REG_X0);
                expanded_o = i_type({4'b0, lwsp_imm}, REG_SP, 3'b010, rd_full, OPC_LOAD);
            end
            {QUAD_2, 3'b110}: begin
                claim_o    = 1'b1;
                legal_o    = 1'b1;
                expanded_o = s_type({4'b0, swsp_imm}, rs2_full, REG_SP, 3'b010, OPC_STORE);
            end
            default: claim_o = 1'b0;
        endcase
    end

endmodule : rvc_mem_expander

//--- testbench/rvc_expander_checker.sv
`timescale 1ns/10ps
//--------------------------------------------------------------------
// Handshake assertions bound into rvc_expander_top
// any_failed stays high once any assertion has fired
//--------------------------------------------------------------------
module rvc_expander_checker import rvc_expand_pkg::*; (
    input logic   clk_i,
    input logic   rst_n_i,
    input logic   req_i,
    input logic   ack_o,
    input instr_t decompressed_o,
    input logic   illegal_o
);

    logic reset_bad = 1'b0;
    logic rise_bad  = 1'b0;
    logic hold_bad  = 1'b0;
    logic fall_bad  = 1'b0;
    logic any_failed;

    assign any_failed = reset_bad | rise_bad | hold_bad | fall_bad;

    //----------------------------------------------------------------
    // Four-phase protocol rules
    //----------------------------------------------------------------

    ack_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !ack_o)
        else begin
            reset_bad = 1'b1;
            $error("ack_o high after a reset cycle");
        end

    // A rising ack_o needs req_i seen at the accepting edge
    ack_rise_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i))
        else begin
            rise_bad = 1'b1;
            $error("ack_o rose without req_i");
        end

    result_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ack_o && $past(ack_o)) |-> ($stable(decompressed_o) && $stable(illegal_o)))
        else begin
            hold_bad = 1'b1;
            $error("Result changed while ack_o was high");
        end

    ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(ack_o) |-> !$past(req_i))
        else begin
            fall_bad = 1'b1;
            $error("ack_o fell while req_i was still high");
        end

endmodule : rvc_expander_checker

//--- testbench/tb_rvc_expander.sv
`timescale 1ns/10ps
//--------------------------------------------------------------------
// Testbench for rvc_expander_top over the four-phase req/ack handshake
// Directed words cover both groups and the dropped encodings, followed
// by 400 random words from a fixed seed
// The run stops at the first mismatch
//--------------------------------------------------------------------
module tb_rvc_expander import rvc_expand_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int RESET_LEN   = 8;
    localparam int N_RANDOM    = 400;
    // 453 transactions of at most 7 cycles each, plus reset and margin
    localparam int CYCLE_LIMIT = 4000;
    localparam int N_DIRECTED  = 53;

    localparam cinstr_t DIRECTED [N_DIRECTED] = '{
        // Memory and stack group with the zero offset and x0 forms
        16'h0044, 16'h1FE0, 16'h0000, 16'h001C, 16'h4188, 16'h5FFC, 16'hC188,
        16'hDFFC, 16'h4082, 16'h5FFE, 16'h4002, 16'h507E, 16'hC006, 16'hDFFE,
        // Arithmetic group with bit 12 and zero register cases
        16'h0505, 16'h1F7D, 16'h0001, 16'h0501, 16'h4515, 16'h557D, 16'h4005,
        16'h8005, 16'h807D, 16'h9005, 16'h8405, 16'h9405, 16'h8811, 16'h987D,
        16'h8C0D, 16'h8C2D, 16'h8C4D, 16'h8C6D, 16'h9C2D, 16'h050A, 16'h150A,
        16'h000A, 16'h852E, 16'h952E, 16'h802E, 16'h902E,
        // Jumps, branches, C.EBREAK, C.LUI, C.ADDI16SP, quadrant 3, C.FLD
        16'hA001, 16'hC001, 16'hE001, 16'h2001, 16'h8082, 16'h9082, 16'h9002,
        16'h6085, 16'h6105, 16'hFFFF, 16'h0013, 16'h4003, 16'h2000
    };

    logic    clk_i;
    logic    rst_n_i;
    logic    req_i;
    cinstr_t compressed_i;
    logic    ack_o;
    instr_t  decompressed_o;
    logic    illegal_o;

    integer      seed = 32'h917f_e191;
    int          cycle_cnt = 0;
    logic        ack_seen = 1'b0;
    logic [31:0] rnd;
    cinstr_t     expect_q [$];

    rvc_expander_top i_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .compressed_i   (compressed_i),
        .ack_o          (ack_o),
        .decompressed_o (decompressed_o),
        .illegal_o      (illegal_o)
    );

    bind rvc_expander_top rvc_expander_checker i_checker (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .ack_o          (ack_o),
        .decompressed_o (decompressed_o),
        .illegal_o      (illegal_o)
    );

    //----------------------------------------------------------------
    // Expected expansion that returns 1 when the word is illegal
    //----------------------------------------------------------------

    function automatic logic expand_ref(input cinstr_t c, output instr_t w);
        reg_idx_t    rd;
        reg_idx_t    rs2;
        reg_idx_t    rdp;
        reg_idx_t    rsp;
        logic [11:0] imm;
        logic [7:0]  off;
        logic [2:0]  f3;
        logic        bad;
        rd  = c[11:7];
        rs2 = c[6:2];
        rdp = {2'b01, c[4:2]};
        rsp = {2'b01, c[9:7]};
        imm = {{7{c[12]}}, c[6:2]};
        w   = 32'd0;
        bad = 1'b0;
        case ({c[1:0], c[15:13]})
            5'b00_000: begin
                w   = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, 3'b000, rdp, 7'h13};
                bad = (c[12:5] == 8'd0);
            end
            5'b00_010: begin
                off = {1'b0, c[5], c[12:10], c[6], 2'b00};
                w   = {4'b0000, off, rsp, 3'b010, rdp, 7'h03};
            end
            5'b00_110: begin
                off = {1'b0, c[5], c[12:10], c[6], 2'b00};
                w   = {4'b0000, off[7:5], rdp, rsp, 3'b010, off[4:0], 7'h23};
            end
            5'b10_010: begin
                off = {c[3:2], c[12], c[6:4], 2'b00};
                w   = {4'b0000, off, 5'd2, 3'b010, rd, 7'h03};
                bad = (rd == 5'd0);
            end
            5'b10_110: begin
                off = {c[8:7], c[12:9], 2'b00};
                w   = {4'b0000, off[7:5], rs2, 5'd2, 3'b010, off[4:0], 7'h23};
            end
            5'b01_000: begin
                w   = {imm, rd, 3'b000, rd, 7'h13};
                bad = (rd == 5'd0) || ({c[12], c[6:2]} == 6'd0);
            end
            5'b01_010: begin
                w   = {imm, 5'd0, 3'b000, rd, 7'h13};
                bad = (rd == 5'd0);
            end
            5'b01_100: begin
                bad = c[12];
                case (c[6:5])
                    2'b00:   f3 = 3'b000;
                    2'b01:   f3 = 3'b100;
                    2'b10:   f3 = 3'b110;
                    default: f3 = 3'b111;
                endcase
                if (c[11:10] == 2'b00) begin
                    w = {7'h00, c[6:2], rsp, 3'b101, rsp, 7'h13};
                end else if (c[11:10] == 2'b01) begin
                    w = {7'h20, c[6:2], rsp, 3'b101, rsp, 7'h13};
                end else if (c[11:10] == 2'b10) begin
                    w   = {imm, rsp, 3'b111, rsp, 7'h13};
                    bad = 1'b0;
                end else begin
                    // Only SUB carries the alternate funct7
                    w = {(c[6:5] == 2'b00) ? 7'h20 : 7'h00, rdp, rsp, f3, rsp, 7'h33};
                end
            end
            5'b10_000: begin
                w   = {7'h00, c[6:2], rd, 3'b001, rd, 7'h13};
                bad = c[12] || (rd == 5'd0);
            end
            5'b10_100: begin
                w   = {7'h00, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'h33};
                bad = (rd == 5'd0) || (rs2 == 5'd0);
            end
            default: bad = 1'b1;
        endcase
        return bad;
    endfunction

    //----------------------------------------------------------------
    // Error reporting and compare tasks
    //----------------------------------------------------------------

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_instr(input string what, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s: decompressed_o %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_illegal(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("%s: illegal_o %b, expected %b", what, got, exp));
        end
    endtask

    //----------------------------------------------------------------
    // One full handshake that is entered and left just after a rising edge
    //----------------------------------------------------------------

    task automatic send_word(input cinstr_t word);
        logic [31:0] hold_rnd;
        int          hold;
        int          waited;
        hold_rnd = $random(seed);
        hold     = int'(hold_rnd % 32'd6);
        expect_q.push_back(word);
        compressed_i = word;
        req_i        = 1'b1;
        waited       = 0;
        do begin
            @(posedge clk_i);
            #DRIVE_DLY;
            waited++;
        end while (!ack_o && waited < 4);
        if (waited != 1 || !ack_o) begin
            report_error($sformatf("ack_o for word %h not high one cycle after req_i", word));
        end
        repeat (hold) begin
            @(posedge clk_i);
            #DRIVE_DLY;
            if (!ack_o) begin
                report_error($sformatf("ack_o dropped while req_i held word %h", word));
            end
        end
        req_i  = 1'b0;
        waited = 0;
        do begin
            @(posedge clk_i);
            #DRIVE_DLY;
            waited++;
        end while (ack_o && waited < 4);
        if (waited != 1 || ack_o) begin
            report_error($sformatf("ack_o for word %h did not fall after req_i", word));
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("tests failed");
            $fatal(1, "Cycle limit reached");
        end
    end

    // A broken handshake rule in the bound checker ends the run at once
    always @(posedge i_dut.i_checker.any_failed) begin
        $display("A handshake assertion failed at %0t", $time);
        $display("tests failed");
        $fatal(1, "Handshake assertion failed");
    end

    // Results are taken at the falling edge of the cycle where ack_o rose
    always @(negedge clk_i) begin
        cinstr_t word;
        instr_t  exp_word;
        logic    exp_illegal;
        if (ack_o && !ack_seen) begin
            if (expect_q.size() == 0) begin
                report_error("ack_o rose with no request outstanding");
            end else begin
                word        = expect_q.pop_front();
                exp_illegal = expand_ref(word, exp_word);
                check_illegal($sformatf("word %h", word), illegal_o, exp_illegal);
                if (!exp_illegal) begin
                    check_instr($sformatf("word %h", word), decompressed_o, exp_word);
                end
            end
        end
        ack_seen = ack_o;
    end

    initial begin
        rst_n_i      = 1'b0;
        req_i        = 1'b0;
        compressed_i = 16'h0000;
        repeat (RESET_LEN) @(posedge clk_i);
        #DRIVE_DLY;
        rst_n_i = 1'b1;
        if (ack_o !== 1'b0) begin
            report_error("ack_o not low after reset");
        end
        check_instr("after reset", decompressed_o, 32'd0);
        check_illegal("after reset", illegal_o, 1'b0);

        foreach (DIRECTED[i]) begin
            send_word(DIRECTED[i]);
        end
        repeat (N_RANDOM) begin
            rnd = $random(seed);
            send_word(rnd[15:0]);
        end

        $display("all tests passed");
        $finish;
    end

endmodule : tb_rvc_expander
